// ==== compile.f ====
+incdir+include
design/spwm_ctrl_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/tx_arbiter.sv
design/cmd_sequencer.sv
design/cmd_responder.sv
design/spwm_master_top.sv
tb/spwm_master_tb.sv

// ==== tb/spwm_patterns.txt ====
# op byte value, expect-leds value bits are 2 blue, 1 green, 0 red with 0 lit
# idle value is a cycle count, expect-tx takes the next frame seen on tx
expect-tx        2a 0
expect-leds      00 5
send             c3 0
expect-leds      00 1
expect-tx        6b 0
send-bad-parity  c3 0
send             55 0
expect-leds      00 2
expect-tx        93 0
idle             00 b4
send             c3 0
expect-leds      00 6
expect-tx        6b 0
expect-tx        2a 0
idle             00 cd
send             c3 0
expect-leds      00 2
expect-tx        93 0
expect-tx        6b 0

// ==== tb/spwm_master_tb.sv ====
//************************************************************
// testbench of the rig master, steps read from tb/spwm_patterns.txt
// tx frames are matched in the order they appear on the line
// outputs are sampled on the falling clock edge
//************************************************************
`timescale 1ns/10ps
`include "spwm_cmd_codes.svh"

module spwm_master_tb;

    localparam int CLKS_PER_BIT = 8;
    localparam int FRAME_BITS   = 11;
    localparam int WAIT_LIMIT   = 1200;  // cycles for a phase plus a frame with margin
    localparam int DRIVE_DELAY  = 10;

    typedef struct packed {
        logic       sync;    // sync pulse seen since the previous frame
        logic       parity;
        logic [7:0] data;
    } tx_frame_t;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    logic sync;
    logic led_red;
    logic led_green;
    logic led_blue;

    tx_frame_t frames[$];  // decoded tx frames with the oldest first

    spwm_master_top #(
        .CLKS_PER_BIT   (CLKS_PER_BIT),
        .STARTUP_CYCLES (40),
        .PHASE_CYCLES   (400)
    ) i_spwm_master_top (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .tx        (tx),
        .sync      (sync),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped on a timeout");
    endtask

    task automatic check_reset_state();
        check_value("tx", tx, 1);
        check_value("sync", sync, 0);
        check_value("led_red", led_red, 1);
        check_value("led_green", led_green, 1);
        check_value("led_blue", led_blue, 1);
    endtask

    task automatic check_leds(input logic [2:0] expected);
        @(negedge clk);
        check_value("led_red", led_red, expected[0]);
        check_value("led_green", led_green, expected[1]);
        check_value("led_blue", led_blue, expected[2]);
    endtask

    // start, 8 data bits lsb first, parity, stop
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, ^data ^ bad_parity, data, 1'b0};
        for (int b = 0; b < FRAME_BITS; b++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            rx = bits[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        repeat (CLKS_PER_BIT) @(posedge clk);  // receiver reports during this idle bit
    endtask

    task automatic check_next_frame(input logic [7:0] expected);
        tx_frame_t frame;
        int waited;
        waited = 0;
        while (frames.size() == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (frames.size() == 0) begin
            stop_on_timeout($sformatf("no frame for byte 0x%0h appeared on tx", expected));
        end else begin
            frame = frames.pop_front();
            check_value("tx data", frame.data, expected);
            // ones over data and parity add up to an even count
            check_value("tx parity", frame.parity, $countones(expected) % 2);
            check_value("sync", frame.sync,
                        expected == `CMD_TURN_ON || expected == `CMD_TURN_OFF);
        end
    endtask

    // tx decoder that takes each bit near its middle
    initial begin : tx_monitor
        int offset;
        int bit_pos;
        logic busy;
        logic sync_seen;
        tx_frame_t frame;
        busy = 1'b0;
        sync_seen = 1'b0;
        offset = 0;
        frame = '0;
        forever begin
            @(negedge clk);
            if (sync === 1'b1) sync_seen = 1'b1;
            if (!busy && reset === 1'b0 && tx === 1'b0) begin
                busy = 1'b1;
                offset = 0;
                frame.sync = sync_seen;
                sync_seen = 1'b0;
            end else if (busy) begin
                offset++;
                bit_pos = offset / CLKS_PER_BIT;
                if (offset % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                    if (bit_pos == 0) begin
                        check_value("tx start bit", tx, 0);
                    end else if (bit_pos <= 8) begin
                        frame.data[bit_pos-1] = tx;
                    end else if (bit_pos == 9) begin
                        frame.parity = tx;
                    end else begin
                        check_value("tx stop bit", tx, 1);
                        frames.push_back(frame);
                        busy = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : run_patterns
        int fd;
        int code;
        string op;
        logic [8*256-1:0] rest;
        logic [7:0] data;
        logic [15:0] value;
        reset = 1'b1;
        rx = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (c == 3) reset = 1'b0;
            @(negedge clk);
            check_reset_state();
        end
        @(negedge clk);
        check_reset_state();  // first cycle out of reset
        fd = $fopen("tb/spwm_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file tb/spwm_patterns.txt could not be opened");
            $display("ERRORS FOUND");
            $fatal(1, "no patterns to run");
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op[0] == "#") begin
                code = $fgets(rest, fd);  // skip the comment text
            end else begin
                code = $fscanf(fd, "%h %h", data, value);
                if (code != 2) begin
                    $display("operation %s in the pattern file lacks its byte or value", op);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad pattern file");
                end else if (op == "send") begin
                    send_frame(data, 1'b0);
                end else if (op == "send-bad-parity") begin
                    send_frame(data, 1'b1);
                end else if (op == "expect-tx") begin
                    check_next_frame(data);
                end else if (op == "expect-leds") begin
                    check_leds(value[2:0]);
                end else if (op == "idle") begin
                    repeat (value) @(posedge clk);
                end else begin
                    $display("unknown operation %s in the pattern file", op);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad pattern file");
                end
            end
        end
        $fclose(fd);
        check_value("unread tx frames", frames.size(), 0);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== design/spwm_master_top.sv ====
//************************************************************
// inverter test rig master, serial command side
// clock comes from outside, no oscillator primitive here
// baud rate and timing are fixed by the parameters
//************************************************************
`timescale 1ns/10ps

module spwm_master_top import spwm_ctrl_pkg::*; #(
    parameter int CLKS_PER_BIT   = 4,
    parameter int STARTUP_CYCLES = 24000000,
    parameter int PHASE_CYCLES   = 48000000
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output logic sync,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);

    rx_event_t rx_event;
    tx_req_t ack_req;
    tx_req_t cmd_req;
    logic ack_grant;
    logic cmd_grant;
    logic tx_start;
    logic tx_busy;
    uart_byte_t tx_data;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_event (rx_event)
    );

    cmd_responder i_cmd_responder (
        .clk       (clk),
        .reset     (reset),
        .rx_event  (rx_event),
        .ack_grant (ack_grant),
        .ack_req   (ack_req),
        .led_blue  (led_blue)
    );

    cmd_sequencer #(
        .STARTUP_CYCLES (STARTUP_CYCLES),
        .PHASE_CYCLES   (PHASE_CYCLES)
    ) i_cmd_sequencer (
        .clk       (clk),
        .reset     (reset),
        .cmd_grant (cmd_grant),
        .cmd_req   (cmd_req),
        .sync      (sync),
        .led_red   (led_red),
        .led_green (led_green)
    );

    tx_arbiter i_tx_arbiter (
        .clk       (clk),
        .reset     (reset),
        .ack_req   (ack_req),
        .cmd_req   (cmd_req),
        .tx_busy   (tx_busy),
        .ack_grant (ack_grant),
        .cmd_grant (cmd_grant),
        .tx_start  (tx_start),
        .tx_data   (tx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== design/cmd_responder.sv ====
//************************************************************
// host command decoder, only the toggle code is acted on
// at most one ack is pending, extra toggles only flip the led
//************************************************************
`timescale 1ns/10ps

module cmd_responder import spwm_ctrl_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  rx_event_t rx_event,
    input  logic      ack_grant,
    output tx_req_t   ack_req,
    output logic      led_blue
);

    logic ack_pending;
    logic clean_byte;
    logic toggle_hit;

    assign clean_byte = rx_event.done && !rx_event.parity_err;

    always_comb begin
        toggle_hit = 1'b0;
        if (clean_byte) begin
            case (rx_event.data)
                `CMD_TOGGLE: toggle_hit = 1'b1;
                default:     toggle_hit = 1'b0;  // unknown code, ignored
            endcase
        end
    end

    assign ack_req = '{req: ack_pending, data: `CMD_ACK};

    always_ff @(posedge clk) begin
        if (reset) begin
            led_blue <= LED_OFF;
            ack_pending <= 1'b0;
        end else begin
            if (toggle_hit) begin
                led_blue <= ~led_blue;
                // set wins over a grant in the same cycle, a fresh ack
                ack_pending <= 1'b1;
            end else if (ack_grant) begin
                ack_pending <= 1'b0;
            end
        end
    end

endmodule

// ==== design/cmd_sequencer.sv ====
//************************************************************
// startup delay then alternating turn on / turn off commands
// phase timing is exact and never waits for the transmitter
// a phase must outlast one frame or a command is overwritten
//************************************************************
`timescale 1ns/10ps

module cmd_sequencer import spwm_ctrl_pkg::*; #(
    parameter int STARTUP_CYCLES = 24000000,
    parameter int PHASE_CYCLES   = 48000000
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    cmd_grant,
    output tx_req_t cmd_req,
    output logic    sync,
    output logic    led_red,
    output logic    led_green
);

    seq_state_t state;
    cycle_count_t cnt;
    logic req;
    uart_byte_t req_byte;
    logic startup_done;
    logic phase_done;

    assign startup_done = (cnt == cycle_count_t'(STARTUP_CYCLES - 1));
    assign phase_done   = (cnt == cycle_count_t'(PHASE_CYCLES - 1));

    assign cmd_req = '{req: req, data: req_byte};

    assign led_green = (state == SEQ_PHASE_ON)  ? LED_ON : LED_OFF;
    assign led_red   = (state == SEQ_PHASE_OFF) ? LED_ON : LED_OFF;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_STARTUP;
            cnt <= '0;
            req <= 1'b0;
            sync <= 1'b0;
        end else begin
            sync <= cmd_grant;  // marks the command going out
            cnt <= cnt + 1'b1;
            if (cmd_grant) req <= 1'b0;
            case (state)
                SEQ_STARTUP: begin
                    if (startup_done) begin
                        cnt <= '0;
                        req <= 1'b1;
                        req_byte <= PHASE_ON_BYTE;
                        state <= SEQ_PHASE_ON;
                    end
                end
                SEQ_PHASE_ON: begin
                    if (phase_done) begin
                        cnt <= '0;
                        req <= 1'b1;
                        req_byte <= PHASE_OFF_BYTE;
                        state <= SEQ_PHASE_OFF;
                    end
                end
                SEQ_PHASE_OFF: begin
                    if (phase_done) begin
                        cnt <= '0;
                        req <= 1'b1;
                        req_byte <= PHASE_ON_BYTE;
                        state <= SEQ_PHASE_ON;
                    end
                end
                default: state <= SEQ_STARTUP;
            endcase
        end
    end

endmodule

// ==== design/tx_arbiter.sv ====
//************************************************************
// fixed priority owner select for the shared transmitter
// the ack request always beats the command request
// requests must stay high until their grant pulse
//************************************************************
`timescale 1ns/10ps

module tx_arbiter import spwm_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  tx_req_t    ack_req,
    input  tx_req_t    cmd_req,
    input  logic       tx_busy,
    output logic       ack_grant,
    output logic       cmd_grant,
    output logic       tx_start,
    output uart_byte_t tx_data
);

    logic launch;   // frame start issued, tx_busy not yet up
    logic can_grant;
    logic pick_ack;
    logic pick_cmd;

    assign can_grant = !tx_busy && !launch;
    assign pick_ack  = can_grant && ack_req.req;
    assign pick_cmd  = can_grant && !ack_req.req && cmd_req.req;

    assign tx_start = launch;

    always_ff @(posedge clk) begin
        if (reset) begin
            launch <= 1'b0;
            ack_grant <= 1'b0;
            cmd_grant <= 1'b0;
        end else begin
            launch <= pick_ack || pick_cmd;
            ack_grant <= pick_ack;
            cmd_grant <= pick_cmd;
        end
    end

    // byte of the winner, held for the transmitter
    always_ff @(posedge clk) begin
        if (pick_ack) begin
            tx_data <= ack_req.data;
        end else if (pick_cmd) begin
            tx_data <= cmd_req.data;
        end
    end

endmodule

// ==== design/uart_rx.sv ====
//************************************************************
// uart receiver, 8 data bits, even parity, one stop bit
// bits are sampled at their middle, rx is asynchronous
// a low stop bit is reported as a parity error
//************************************************************
`timescale 1ns/10ps

module uart_rx import spwm_ctrl_pkg::*; #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      rx,
    output rx_event_t rx_event
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    uart_state_t state;
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shreg;
    logic parity_bit;
    logic done;
    logic parity_err;
    uart_byte_t data;
    logic half_end;
    logic bit_end;

    assign half_end = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    assign rx_event = '{done: done, parity_err: parity_err, data: data};

    // two flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= UART_START;  // falling edge
                end
                UART_START: begin
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a short glitch is not a start bit
                        state <= rx_sync ? UART_IDLE : UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        shreg <= {rx_sync, shreg[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= UART_PARITY;
                    end
                end
                UART_PARITY: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        parity_bit <= rx_sync;
                        state <= UART_STOP;
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        done <= 1'b1;
                        data <= shreg;
                        parity_err <= (^shreg != parity_bit) || !rx_sync;
                        state <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

// ==== design/uart_tx.sv ====
//************************************************************
// uart transmitter, 8 data bits, even parity, one stop bit
// tx_start is taken only while tx_busy is low
// CLKS_PER_BIT must be at least 4
//************************************************************
`timescale 1ns/10ps

module uart_tx import spwm_ctrl_pkg::*; #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_start,
    input  uart_byte_t tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    uart_state_t state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shreg;
    logic parity_bit;
    logic bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_busy = (state != UART_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx <= 1'b1;  // line idles high
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    tx <= 1'b1;
                    clk_cnt <= '0;
                    if (tx_start) begin
                        shreg <= tx_data;
                        parity_bit <= ^tx_data;  // makes the ones count even
                        tx <= 1'b0;              // start bit
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        tx <= shreg[0];
                        bit_idx <= '0;
                        state <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        shreg <= shreg >> 1;
                        if (bit_idx == 3'd7) begin
                            tx <= parity_bit;
                            state <= UART_PARITY;
                        end else begin
                            tx <= shreg[1];  // next data bit, lsb first
                        end
                    end
                end
                UART_PARITY: begin
                    if (bit_end) begin
                        tx <= 1'b1;  // stop bit
                        state <= UART_STOP;
                    end
                end
                UART_STOP: begin
                    if (bit_end) state <= UART_IDLE;
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

endmodule

// ==== design/spwm_ctrl_pkg.sv ====
//************************************************************
// shared types of the inverter rig master
// brings in the command byte macros for every later file
// leds on the board are active low
//************************************************************
package spwm_ctrl_pkg;

`include "spwm_cmd_codes.svh"

    typedef logic [7:0]  uart_byte_t;    // one data byte on the link
    typedef logic [31:0] cycle_count_t;  // delay and period counter

    // transmit request, held until granted
    typedef struct packed {
        logic       req;
        uart_byte_t data;
    } tx_req_t;

    // receiver report, valid while done is high
    typedef struct packed {
        logic       done;
        logic       parity_err;  // also set on a low stop bit
        uart_byte_t data;
    } rx_event_t;

    typedef enum logic [1:0] {
        SEQ_STARTUP,
        SEQ_PHASE_ON,
        SEQ_PHASE_OFF
    } seq_state_t;

    typedef enum logic [2:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_PARITY,
        UART_STOP
    } uart_state_t;

    localparam logic LED_ON  = 1'b0;
    localparam logic LED_OFF = 1'b1;

    // byte sent by the sequencer for each phase
    localparam uart_byte_t PHASE_ON_BYTE  = `CMD_TURN_ON;
    localparam uart_byte_t PHASE_OFF_BYTE = `CMD_TURN_OFF;

endpackage

// ==== include/spwm_cmd_codes.svh ====
//************************************************************
// command byte values of the master/module serial link
// all codes are 8 bits, sent with even parity
// unknown codes are ignored by the receiving side
//************************************************************
`ifndef SPWM_CMD_CODES_SVH
`define SPWM_CMD_CODES_SVH

// master to modules
`define CMD_TURN_ON  8'h2A  // start the on phase
`define CMD_TURN_OFF 8'h93  // start the off phase

// host to master
`define CMD_TOGGLE   8'hC3  // flip the blue led

// master to host, answer to a toggle
`define CMD_ACK      8'h6B

`endif
